//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = median_filter_tb
RTL_TOP   = median_filter_top
FILE_LIST = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation finished cleanly"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/median_filter_assert.sv
/*
  Concurrent checks bound into the rank cells and the output stage.
  CHECK_OUTPUT picks the output checks, otherwise the chain ordering check.
*/
`timescale 1ns/1ns

module median_filter_assert #(
  parameter bit CHECK_OUTPUT = 1'b0
) (
  input logic              CLK,
  input logic              RST,
  input pixel_pkg::pixel_t lower,
  input pixel_pkg::pixel_t upper,
  input logic              out_valid,
  input pixel_pkg::pixel_t dout
);

  if (CHECK_OUTPUT) begin : g_output
    // no result in the first cycles after reset release
    assert property (@(posedge CLK) $past(RST, 3) |-> !out_valid)
      else $error("out_valid high too soon after reset release");
    // dout only moves together with a valid pulse
    assert property (@(posedge CLK) disable iff (RST) !out_valid |-> $stable(dout))
      else $error("dout changed while out_valid was low");
  end else begin : g_order
    // a cell never sits below its lower neighbour
    assert property (@(posedge CLK) disable iff (RST) lower <= upper)
      else $error("rank chain out of order, %h above %h", lower, upper);
  end

endmodule

// one ordering checker per rank cell
bind rank_cell median_filter_assert #(
  .CHECK_OUTPUT (1'b0)
) order_assert_inst (
  .CLK       (CLK),
  .RST       (RST),
  .lower     (prev),
  .upper     (value),
  .out_valid (1'b0),
  .dout      (value)
);

bind median_out median_filter_assert #(
  .CHECK_OUTPUT (1'b1)
) output_assert_inst (
  .CLK       (CLK),
  .RST       (RST),
  .lower     (median),
  .upper     (median),
  .out_valid (out_valid),
  .dout      (dout)
);

//--- bench/median_filter_tb.sv
/*
  Directed testbench for the running-median filter.
  A queue model of the window predicts every median, a negedge monitor checks dout and out_valid.
*/
`timescale 1ns/1ns

module median_filter_tb;

  import pixel_pkg::*;
  import window_pkg::*;

  localparam int WINDOW_LEN    = DEFAULT_WINDOW_LEN;
  localparam int RANDOM_LEN    = 200;
  localparam int GAPPED_LEN    = 40;
  localparam int EXTREME_LEN   = 5 * WINDOW_LEN;
  localparam int RESET_LEN     = 10 + WINDOW_LEN;
  localparam int TOTAL_STROBES = WINDOW_LEN + RANDOM_LEN + GAPPED_LEN + EXTREME_LEN + RESET_LEN;
  localparam int CYCLE_LIMIT   = 3 * TOTAL_STROBES + 200;

  logic   CLK;
  logic   RST;
  pixel_t din;
  logic   in_en;
  logic   out_valid;
  pixel_t dout;

  logic [31:0] rng_state = 32'd81656;
  int          cycle;
  int          err_count;
  int          err_start;
  int          tests_passed;
  int          tests_failed;
  string       test_name;
  pixel_t      held_dout;

  // model window, oldest sample at index 0
  pixel_t hist_q[$];
  // expected medians and the cycle each one is due
  pixel_t exp_val_q[$];
  int     exp_due_q[$];

  median_filter_top median_filter_top_inst (
    .CLK       (CLK),
    .RST       (RST),
    .din       (din),
    .in_en     (in_en),
    .out_valid (out_valid),
    .dout      (dout)
  );

  always #5 CLK = ~CLK;

  // cycle count and run limit
  always @(posedge CLK) begin
    cycle = cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("timeout: run reached %0d cycles without finishing the tests", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic pixel_t rand_pixel();
    logic [31:0] r;
    r = next_rand();
    return r[23:16];
  endfunction

  // median of the model window by sorting a copy
  function automatic pixel_t model_median();
    pixel_t sorted [WINDOW_LEN];
    pixel_t tmp;
    for (int i = 0; i < WINDOW_LEN; i++) begin
      sorted[i] = hist_q[i];
    end
    for (int i = 0; i < WINDOW_LEN - 1; i++) begin
      for (int j = 0; j < WINDOW_LEN - 1 - i; j++) begin
        if (sorted[j] > sorted[j+1]) begin
          tmp         = sorted[j];
          sorted[j]   = sorted[j+1];
          sorted[j+1] = tmp;
        end
      end
    end
    return sorted[WINDOW_LEN/2];
  endfunction

  task automatic check_pixel(input pixel_t actual, input pixel_t expected);
    if (actual !== expected) begin
      $display("error %s: dout expected %h, actual %h", test_name, expected, actual);
      err_count++;
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("error %s: out_valid expected %b, actual %b", test_name, expected, actual);
      err_count++;
    end
  endtask

  // one strobe, result due two edges after the strobe edge
  task automatic strobe(input pixel_t v);
    din   = v;
    in_en = 1'b1;
    hist_q.push_back(v);
    if (hist_q.size() > WINDOW_LEN) begin
      void'(hist_q.pop_front());
    end
    if (hist_q.size() == WINDOW_LEN) begin
      exp_val_q.push_back(model_median());
      exp_due_q.push_back(cycle + 2);
    end
    @(posedge CLK);
    #1;
    in_en = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic apply_reset();
    RST = 1'b1;
    hist_q.delete();
    exp_val_q.delete();
    exp_due_q.delete();
    repeat (3) @(posedge CLK);
    #1;
    RST = 1'b0;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_start = err_count;
  endtask

  task automatic end_test();
    while (exp_val_q.size() > 0) begin
      idle(1);
    end
    idle(2);
    if (err_count == err_start) begin
      tests_passed++;
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, err_count - err_start);
    end
  endtask

  task automatic test_fill();
    begin_test("fill");
    for (int i = 0; i < WINDOW_LEN; i++) begin
      strobe(rand_pixel());
    end
    end_test();
  endtask

  task automatic test_random();
    begin_test("random_stream");
    for (int i = 0; i < RANDOM_LEN; i++) begin
      strobe(rand_pixel());
    end
    end_test();
  endtask

  task automatic test_gapped();
    logic [31:0] r;
    begin_test("gapped_strobes");
    for (int i = 0; i < GAPPED_LEN; i++) begin
      strobe(rand_pixel());
      r = next_rand();
      idle(int'(r % 32'd5));
    end
    end_test();
  endtask

  task automatic test_extremes();
    begin_test("extremes_duplicates");
    for (int i = 0; i < WINDOW_LEN; i++) begin
      strobe(PIXEL_MAX);
    end
    for (int i = 0; i < WINDOW_LEN; i++) begin
      strobe(PIXEL_MIN);
    end
    for (int i = 0; i < WINDOW_LEN; i++) begin
      strobe(8'h5a);
    end
    for (int i = 0; i < WINDOW_LEN; i++) begin
      strobe(rand_pixel());
    end
    // inserted sample equals the one that leaves
    for (int i = 0; i < WINDOW_LEN; i++) begin
      strobe(hist_q[0]);
    end
    end_test();
  endtask

  task automatic test_reset();
    begin_test("reset_mid_stream");
    for (int i = 0; i < 10; i++) begin
      strobe(rand_pixel());
    end
    apply_reset();
    for (int i = 0; i < WINDOW_LEN; i++) begin
      strobe(rand_pixel());
    end
    end_test();
  endtask

  // expected level of out_valid follows the due list
  always @(negedge CLK) begin : output_monitor
    logic want;
    want = 1'b0;
    if (RST) begin
      held_dout = PIXEL_MIN;
    end else begin
      if (exp_due_q.size() > 0) begin
        want = (exp_due_q[0] == cycle);
      end
      check_flag(out_valid, want);
      if (want) begin
        if (out_valid) begin
          check_pixel(dout, exp_val_q[0]);
          held_dout = exp_val_q[0];
        end
        void'(exp_val_q.pop_front());
        void'(exp_due_q.pop_front());
      end else begin
        check_pixel(dout, held_dout);
      end
    end
  end

  initial begin
    CLK          = 1'b0;
    RST          = 1'b1;
    din          = PIXEL_MIN;
    in_en        = 1'b0;
    cycle        = 0;
    err_count    = 0;
    err_start    = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_name    = "init";
    held_dout    = PIXEL_MIN;
    apply_reset();
    test_fill();
    test_random();
    test_gapped();
    test_extremes();
    test_reset();
    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
src/pixel_pkg.sv
src/window_pkg.sv
src/window_history.sv
src/rank_cell.sv
src/rank_sorter.sv
src/median_out.sv
src/median_filter_top.sv
bench/median_filter_assert.sv
bench/median_filter_tb.sv

//--- src/median_filter_top.sv
/*
  Running-median filter over a stream of 8-bit samples, one result per strobe.
  Output appears two edges after the strobe edge once WINDOW_LEN samples are in.
*/
`timescale 1ns/1ns

module median_filter_top #(
  parameter int WINDOW_LEN = window_pkg::DEFAULT_WINDOW_LEN
) (
  input  logic              CLK,
  input  logic              RST,
  input  pixel_pkg::pixel_t din,
  input  logic              in_en,
  output logic              out_valid,
  output pixel_pkg::pixel_t dout
);

  import pixel_pkg::*;

  // sample leaving the window on this strobe
  pixel_t oldest;
  // window full after the last strobe
  logic   window_ready;
  // middle rank after the last strobe
  pixel_t median;

  // history and sorter run side by side on the same strobe
  window_history #(
    .WINDOW_LEN (WINDOW_LEN)
  ) window_history_inst (
    .CLK          (CLK),
    .RST          (RST),
    .din          (din),
    .in_en        (in_en),
    .oldest       (oldest),
    .window_ready (window_ready)
  );

  rank_sorter #(
    .WINDOW_LEN (WINDOW_LEN)
  ) rank_sorter_inst (
    .CLK    (CLK),
    .RST    (RST),
    .in_en  (in_en),
    .din    (din),
    .oldest (oldest),
    .median (median)
  );

  median_out median_out_inst (
    .CLK          (CLK),
    .RST          (RST),
    .window_ready (window_ready),
    .median       (median),
    .out_valid    (out_valid),
    .dout         (dout)
  );

endmodule

//--- src/median_out.sv
/*
  Output stage of the running-median filter.
  Registers the median one cycle after a full-window update and pulses out_valid.
*/
`timescale 1ns/1ns

module median_out (
  input  logic              CLK,
  input  logic              RST,
  input  logic              window_ready,
  input  pixel_pkg::pixel_t median,
  output logic              out_valid,
  output pixel_pkg::pixel_t dout
);

  import pixel_pkg::*;

  // valid pulse follows window_ready by one cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= window_ready;
    end
  end

  // dout keeps its last median between pulses
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      dout <= PIXEL_MIN;
    end else if (window_ready) begin
      dout <= median;
    end
  end

endmodule

//--- src/pixel_pkg.sv
/*
  Sample type for the running-median datapath and its bench.
  The two extreme values bound the rank chain and mark empty slots.
*/
package pixel_pkg;

  // one 8-bit stream sample
  typedef logic [7:0] pixel_t;

  // lowest sample value, seen below the first rank cell
  localparam pixel_t PIXEL_MIN = 8'h00;

  // highest sample value, seen above the last rank cell
  // also the empty-slot marker, so a partly filled window
  // simply holds all ones in the slots not yet written
  localparam pixel_t PIXEL_MAX = 8'hff;

endpackage

//--- src/rank_cell.sv
/*
  One cell of the sorted rank array.
  On each update it makes room for the inserted sample or closes the gap of the deleted one.
*/
`timescale 1ns/1ns

module rank_cell (
  input  logic              CLK,
  input  logic              RST,
  input  pixel_pkg::pixel_t ins,
  input  pixel_pkg::pixel_t del,
  input  pixel_pkg::pixel_t prev,
  input  pixel_pkg::pixel_t next,
  output pixel_pkg::pixel_t value
);

  import pixel_pkg::*;

  pixel_t value_r;
  pixel_t value_nxt;

  assign value = value_r;

  always_comb begin
    value_nxt = value_r;
    if (ins < del) begin
      // smaller sample enters, entries in (ins, del] move up one rank
      if ((value_r > ins) && (value_r <= del)) begin
        value_nxt = (prev > ins) ? prev : ins;
      end
    end else if (ins > del) begin
      // larger sample enters, entries in [del, ins) move down one rank
      if ((value_r < ins) && (value_r >= del)) begin
        value_nxt = (next < ins) ? next : ins;
      end
    end
    // equal values leave the array as it is
  end

  // empty cell holds the all-ones marker
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      value_r <= PIXEL_MAX;
    end else begin
      value_r <= value_nxt;
    end
  end

endmodule

//--- src/rank_sorter.sv
/*
  Sorted array of WINDOW_LEN rank cells, ascending from index 0.
  Insert and delete happen in the same cycle; the middle cell is the median.
*/
`timescale 1ns/1ns

module rank_sorter #(
  parameter int WINDOW_LEN = window_pkg::DEFAULT_WINDOW_LEN
) (
  input  logic              CLK,
  input  logic              RST,
  input  logic              in_en,
  input  pixel_pkg::pixel_t din,
  input  pixel_pkg::pixel_t oldest,
  output pixel_pkg::pixel_t median
);

  import pixel_pkg::*;

  pixel_t ins_val;
  pixel_t del_val;
  pixel_t cell_val [WINDOW_LEN];

  // idle cycle presents equal insert and delete, so no cell moves
  assign ins_val = in_en ? din : PIXEL_MAX;
  assign del_val = in_en ? oldest : PIXEL_MAX;

  for (genvar i = 0; i < WINDOW_LEN; i++) begin : g_cell
    pixel_t prev_val;
    pixel_t next_val;

    // lower neighbour, bottom of chain sees the minimum
    if (i == 0) begin : g_bottom
      assign prev_val = PIXEL_MIN;
    end else begin : g_lower
      assign prev_val = cell_val[i-1];
    end

    // upper neighbour, top of chain sees the maximum
    if (i == WINDOW_LEN - 1) begin : g_top
      assign next_val = PIXEL_MAX;
    end else begin : g_upper
      assign next_val = cell_val[i+1];
    end

    rank_cell rank_cell_inst (
      .CLK   (CLK),
      .RST   (RST),
      .ins   (ins_val),
      .del   (del_val),
      .prev  (prev_val),
      .next  (next_val),
      .value (cell_val[i])
    );
  end

  // middle rank of an odd-length window
  assign median = cell_val[WINDOW_LEN/2];

endmodule

//--- src/window_history.sv
/*
  Delay line of the last WINDOW_LEN samples with fill tracking.
  Presents the sample about to leave the window and flags a full window.
*/
`timescale 1ns/1ns

module window_history #(
  parameter int WINDOW_LEN = window_pkg::DEFAULT_WINDOW_LEN
) (
  input  logic              CLK,
  input  logic              RST,
  input  pixel_pkg::pixel_t din,
  input  logic              in_en,
  output pixel_pkg::pixel_t oldest,
  output logic              window_ready
);

  import pixel_pkg::*;
  import window_pkg::*;

  // count value when the strobe in flight is the WINDOW_LEN-th one
  localparam fill_cnt_t LAST_FILL = fill_cnt_t'(WINDOW_LEN - 1);

  pixel_t      hist [WINDOW_LEN];
  fill_cnt_t   fill_cnt;
  fill_state_t state;
  logic        full_after;

  // the last entry leaves the window on the next strobe
  assign oldest = hist[WINDOW_LEN-1];

  // window holds WINDOW_LEN real samples once this strobe is taken
  assign full_after = in_en && ((state == FULL) || (fill_cnt == LAST_FILL));

  // shift register, empty slots hold the all-ones marker
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < WINDOW_LEN; i++) begin
        hist[i] <= PIXEL_MAX;
      end
    end else if (in_en) begin
      hist[0] <= din;
      for (int i = 1; i < WINDOW_LEN; i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

  // fill tracker FSM with its sample counter
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= FILLING;
      fill_cnt <= '0;
    end else begin
      case (state)
        FILLING: begin
          if (in_en) begin
            fill_cnt <= fill_cnt + fill_cnt_t'(1);
            if (fill_cnt == LAST_FILL) begin
              state <= FULL;
            end
          end
        end
        FULL: begin
          // stays here until reset
          state <= FULL;
        end
        default: begin
          state <= FILLING;
        end
      endcase
    end
  end

  // one pulse per accepted strobe once the window is full
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      window_ready <= 1'b0;
    end else begin
      window_ready <= full_after;
    end
  end

endmodule

//--- src/window_pkg.sv
/*
  Window geometry and fill-tracking types for the running-median filter.
  The default length is set on the top level and passed down.
*/
package window_pkg;

  // default number of samples in the window, must be odd
  localparam int DEFAULT_WINDOW_LEN = 7;

  // samples taken since reset, 4 bits allow windows up to 15
  typedef logic [3:0] fill_cnt_t;

  // fill tracker states
  // FILLING until the window has been loaded once, then FULL until reset
  typedef enum logic {
    FILLING,
    FULL
  } fill_state_t;

endpackage
